/* verilog/panel_pkg.sv */
//############################################################
// sized for panels up to 64x32, rgb 8 bits per channel
// command word is opcode-led with two field layouts
//############################################################
package panel_pkg;

    localparam int COL_BITS        = 6;
    localparam int ROW_BITS        = 5;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int PIX_BITS        = 2;

    typedef enum logic [3:0] {
        OP_NOP       = 4'h0,
        OP_BLANK     = 4'h1,
        OP_FILL_RECT = 4'h2,
        OP_SET_PIXEL = 4'h3
    } opcode_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [COL_BITS-1:0] x1;
        logic [ROW_BITS-1:0] y1;
        logic [COL_BITS:0]   width;   // one extra bit so a full row fits
        logic [ROW_BITS:0]   height;
        logic [23:0]         colour;
    } rect_view_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [COL_BITS-1:0] x;
        logic [ROW_BITS-1:0] y;
        logic [12:0]         pad;
        logic [23:0]         colour;  // same slot as the rect view
    } pixel_view_t;

    typedef union packed {
        rect_view_t  rect;
        pixel_view_t pixel;
    } cmd_word_t;

    localparam int CMD_BITS = $bits(cmd_word_t);

    typedef struct packed {
        logic [COL_BITS-1:0] x1;
        logic [ROW_BITS-1:0] y1;
        logic [COL_BITS:0]   width;
        logic [ROW_BITS:0]   height;
        logic [23:0]         colour;
    } rect_t;

    // shared by both command FSMs
    typedef enum logic [1:0] {
        ST_START,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } ctrl_state_t;

endpackage

/* verilog/fill_bus_if.sv */
//############################################################
// one byte write per cycle, no back-pressure
//############################################################
`timescale 1ns/1ps

interface fill_bus_if import panel_pkg::*; ();

    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] column;
    logic [PIX_BITS-1:0] pixel;
    logic [7:0]          data;
    logic                write_enable;
    logic                access_start;   // first byte of a pixel

    modport source (
        output row,
        output column,
        output pixel,
        output data,
        output write_enable,
        output access_start
    );

    modport sink (
        input row,
        input column,
        input pixel,
        input data,
        input write_enable,
        input access_start
    );

endinterface

/* verilog/subcmd_fill_area.sv */
//############################################################
// area must be stable when enable rises; done holds until ack
// rectangles are clipped to the panel, off-panel origin writes none
//############################################################
`timescale 1ns/1ps

module subcmd_fill_area import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  logic         ack,
    input  rect_t        area,
    fill_bus_if.source   bus,
    output logic         done
);

    localparam logic [COL_BITS:0] PANEL_W = (COL_BITS+1)'(PANEL_WIDTH);
    localparam logic [ROW_BITS:0] PANEL_H = (ROW_BITS+1)'(PANEL_HEIGHT);
    localparam logic [PIX_BITS-1:0] LAST_PIX = PIX_BITS'(BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        FA_IDLE,
        FA_RUN,
        FA_DONE
    } fill_state_t;

    fill_state_t         state;
    logic [COL_BITS:0]   room_w;
    logic [ROW_BITS:0]   room_h;
    logic [COL_BITS:0]   clip_w;
    logic [ROW_BITS:0]   clip_h;
    logic                empty;
    logic                last;
    logic [COL_BITS-1:0] col;
    logic [COL_BITS-1:0] col_first;
    logic [COL_BITS-1:0] col_last;
    logic [ROW_BITS-1:0] row;
    logic [ROW_BITS-1:0] row_last;
    logic [PIX_BITS-1:0] pix;
    logic [23:0]         colour;

    always_comb begin
        room_w = PANEL_W - {1'b0, area.x1};   // wraps when outside, masked by empty
        room_h = PANEL_H - {1'b0, area.y1};
        clip_w = (area.width > room_w) ? room_w : area.width;
        clip_h = (area.height > room_h) ? room_h : area.height;
        empty  = ({1'b0, area.x1} >= PANEL_W) || ({1'b0, area.y1} >= PANEL_H) ||
                 (clip_w == '0) || (clip_h == '0);
    end

    assign last = (pix == LAST_PIX) && (col == col_last) && (row == row_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FA_IDLE;
        end else begin
            case (state)
                FA_IDLE: begin
                    if (enable) begin
                        state <= empty ? FA_DONE : FA_RUN;
                    end
                end
                FA_RUN: begin
                    if (last) begin
                        state <= FA_DONE;
                    end
                end
                FA_DONE: begin
                    if (ack) begin
                        state <= FA_IDLE;
                    end
                end
                default: state <= FA_IDLE;
            endcase
        end
    end

    // walk rows, then columns, then bytes
    always_ff @(posedge clk) begin
        if (state == FA_IDLE) begin
            col       <= area.x1;
            col_first <= area.x1;
            col_last  <= COL_BITS'({1'b0, area.x1} + clip_w - 1'b1);
            row       <= area.y1;
            row_last  <= ROW_BITS'({1'b0, area.y1} + clip_h - 1'b1);
            pix       <= '0;
            colour    <= area.colour;
        end else if (state == FA_RUN) begin
            if (pix == LAST_PIX) begin
                pix <= '0;
                if (col == col_last) begin
                    col <= col_first;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                pix <= pix + 1'b1;
            end
        end
    end

    always_comb begin
        case (pix)
            2'd0:    bus.data = colour[23:16];   // red
            2'd1:    bus.data = colour[15:8];    // green
            default: bus.data = colour[7:0];     // blue
        endcase
    end

    assign bus.row          = row;
    assign bus.column       = col;
    assign bus.pixel        = pix;
    assign bus.write_enable = (state == FA_RUN);
    assign bus.access_start = (state == FA_RUN) && (pix == '0);
    assign done             = (state == FA_DONE);

endmodule

/* verilog/cmd_blank_panel.sv */
//############################################################
// clears the whole panel to zero; enable held until done
//############################################################
`timescale 1ns/1ps

module cmd_blank_panel import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    fill_bus_if.source bus,
    output logic       done
);

    localparam rect_t FULL_PANEL = '{
        x1:     '0,
        y1:     '0,
        width:  (COL_BITS+1)'(PANEL_WIDTH),
        height: (ROW_BITS+1)'(PANEL_HEIGHT),
        colour: 24'h000000
    };

    ctrl_state_t state;
    logic        subcmd_enable;
    logic        subcmd_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_START;
            subcmd_enable <= 1'b0;
            done          <= 1'b0;
        end else begin
            case (state)
                ST_START: begin
                    if (enable) begin
                        subcmd_enable <= 1'b1;
                        state         <= ST_RUNNING;
                    end
                end
                ST_RUNNING: begin
                    if (enable && subcmd_done) begin
                        subcmd_enable <= 1'b0;
                        state         <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    if (enable) begin
                        done  <= 1'b1;   // also acks the engine
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    done  <= 1'b0;
                    state <= ST_START;
                end
                default: state <= ST_START;
            endcase
        end
    end

    subcmd_fill_area #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) fill_engine (
        .clk   (clk),
        .reset (reset),
        .enable(subcmd_enable),
        .ack   (done),
        .area  (FULL_PANEL),
        .bus   (bus),
        .done  (subcmd_done)
    );

endmodule

/* verilog/cmd_fill_rect.sv */
//############################################################
// fill_rect and set_pixel; word taken from the cmd_valid cycle
//############################################################
`timescale 1ns/1ps

module cmd_fill_rect import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  cmd_word_t  cmd,
    fill_bus_if.source bus,
    output logic       done
);

    ctrl_state_t state;
    cmd_word_t   cmd_q;
    rect_t       area;
    logic        subcmd_enable;
    logic        subcmd_done;

    // tracks cmd while idle, frozen once enable is seen
    always_ff @(posedge clk) begin
        if (state == ST_START && !enable) begin
            cmd_q <= cmd;
        end
    end

    always_comb begin
        if (cmd_q.pixel.opcode == OP_SET_PIXEL) begin
            area.x1     = cmd_q.pixel.x;
            area.y1     = cmd_q.pixel.y;
            area.width  = (COL_BITS+1)'(1);   // single pixel
            area.height = (ROW_BITS+1)'(1);
            area.colour = cmd_q.pixel.colour;
        end else begin
            area.x1     = cmd_q.rect.x1;
            area.y1     = cmd_q.rect.y1;
            area.width  = cmd_q.rect.width;
            area.height = cmd_q.rect.height;
            area.colour = cmd_q.rect.colour;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_START;
            subcmd_enable <= 1'b0;
            done          <= 1'b0;
        end else begin
            case (state)
                ST_START: begin
                    if (enable) begin
                        subcmd_enable <= 1'b1;
                        state         <= ST_RUNNING;
                    end
                end
                ST_RUNNING: begin
                    if (enable && subcmd_done) begin
                        subcmd_enable <= 1'b0;
                        state         <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    if (enable) begin
                        done  <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    done  <= 1'b0;
                    state <= ST_START;
                end
                default: state <= ST_START;
            endcase
        end
    end

    subcmd_fill_area #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) fill_engine (
        .clk   (clk),
        .reset (reset),
        .enable(subcmd_enable),
        .ack   (done),
        .area  (area),
        .bus   (bus),
        .done  (subcmd_done)
    );

endmodule

/* verilog/command_dispatch.sv */
//############################################################
// cmd_valid ignored while a command runs; busy drops with done
//############################################################
`timescale 1ns/1ps

module command_dispatch import panel_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_valid,
    input  cmd_word_t  cmd,
    input  logic       blank_done,
    input  logic       rect_done,
    fill_bus_if.sink   blank_bus,
    fill_bus_if.sink   rect_bus,
    fill_bus_if.source ram_bus,
    output logic       blank_enable,
    output logic       rect_enable,
    output logic       busy,
    output logic       done
);

    opcode_t op;
    logic    active;
    logic    nop_done;

    assign op     = cmd.rect.opcode;
    assign active = blank_enable || rect_enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            blank_enable <= 1'b0;
            rect_enable  <= 1'b0;
            nop_done     <= 1'b0;
        end else begin
            nop_done <= 1'b0;
            if (cmd_valid && !active) begin
                case (op)
                    OP_BLANK:                  blank_enable <= 1'b1;
                    OP_FILL_RECT, OP_SET_PIXEL: rect_enable <= 1'b1;
                    default:                   nop_done     <= 1'b1;   // nop and unknown
                endcase
            end
            if (blank_done) begin
                blank_enable <= 1'b0;
            end
            if (rect_done) begin
                rect_enable <= 1'b0;
            end
        end
    end

    assign done = nop_done || (blank_enable && blank_done) || (rect_enable && rect_done);
    assign busy = (blank_enable && !blank_done) || (rect_enable && !rect_done);

    always_comb begin
        if (blank_enable) begin
            ram_bus.row    = blank_bus.row;
            ram_bus.column = blank_bus.column;
            ram_bus.pixel  = blank_bus.pixel;
            ram_bus.data   = blank_bus.data;
        end else begin
            ram_bus.row    = rect_bus.row;
            ram_bus.column = rect_bus.column;
            ram_bus.pixel  = rect_bus.pixel;
            ram_bus.data   = rect_bus.data;
        end
        ram_bus.write_enable = (blank_enable && blank_bus.write_enable) ||
                               (rect_enable && rect_bus.write_enable);
        ram_bus.access_start = (blank_enable && blank_bus.access_start) ||
                               (rect_enable && rect_bus.access_start);
    end

endmodule

/* verilog/frame_ram.sv */
//############################################################
// reads outside the panel return undefined data
//############################################################
`timescale 1ns/1ps

module frame_ram import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic                clk,
    fill_bus_if.sink            bus,
    input  logic [ROW_BITS-1:0] rd_row,
    input  logic [COL_BITS-1:0] rd_column,
    input  logic [PIX_BITS-1:0] rd_pixel,
    output logic [7:0]          rd_data
);

    localparam int DEPTH     = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int ADDR_BITS = $clog2(DEPTH);

    logic [7:0]           mem [DEPTH];
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    // row major, three bytes per pixel
    function automatic logic [ADDR_BITS-1:0] byte_addr(
        input logic [ROW_BITS-1:0] r,
        input logic [COL_BITS-1:0] c,
        input logic [PIX_BITS-1:0] p
    );
        int unsigned lin;
        lin = (int'(r) * PANEL_WIDTH + int'(c)) * BYTES_PER_PIXEL + int'(p);
        return ADDR_BITS'(lin);
    endfunction

    assign wr_addr = byte_addr(bus.row, bus.column, bus.pixel);
    assign rd_addr = byte_addr(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (bus.write_enable) begin
            mem[wr_addr] <= bus.data;
        end
        rd_data <= mem[rd_addr];   // one cycle latency
    end

endmodule

/* verilog/panel_ctrl_top.sv */
//############################################################
// hold cmd stable through the cmd_valid cycle
//############################################################
`timescale 1ns/1ps

module panel_ctrl_top import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 32,
    parameter int PANEL_HEIGHT = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  logic [CMD_BITS-1:0] cmd,
    input  logic [ROW_BITS-1:0] rd_row,
    input  logic [COL_BITS-1:0] rd_column,
    input  logic [PIX_BITS-1:0] rd_pixel,
    output logic                busy,
    output logic                done,
    output logic [7:0]          rd_data
);

    logic blank_enable;
    logic rect_enable;
    logic blank_done;
    logic rect_done;

    fill_bus_if blank_bus ();
    fill_bus_if rect_bus ();
    fill_bus_if ram_bus ();

    command_dispatch dispatch (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .blank_done  (blank_done),
        .rect_done   (rect_done),
        .blank_bus   (blank_bus.sink),
        .rect_bus    (rect_bus.sink),
        .ram_bus     (ram_bus.source),
        .blank_enable(blank_enable),
        .rect_enable (rect_enable),
        .busy        (busy),
        .done        (done)
    );

    cmd_blank_panel #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) blank_cmd (
        .clk   (clk),
        .reset (reset),
        .enable(blank_enable),
        .bus   (blank_bus.source),
        .done  (blank_done)
    );

    cmd_fill_rect #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) rect_cmd (
        .clk   (clk),
        .reset (reset),
        .enable(rect_enable),
        .cmd   (cmd),
        .bus   (rect_bus.source),
        .done  (rect_done)
    );

    frame_ram #(
        .PANEL_WIDTH (PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) ram (
        .clk      (clk),
        .bus      (ram_bus.sink),
        .rd_row   (rd_row),
        .rd_column(rd_column),
        .rd_pixel (rd_pixel),
        .rd_data  (rd_data)
    );

endmodule

/* verification/panel_ctrl_asserts.sv */
//############################################################
// bound to command_dispatch, quiet while reset is high
//############################################################
`timescale 1ns/1ps

module panel_ctrl_asserts (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic blank_enable,
    input logic rect_enable,
    input logic ram_write_enable,
    input logic ram_access_start
);

    int unsigned fail_count = 0;   // read by the testbench at the end

    done_not_busy: assert property (@(posedge clk) disable iff (reset) !(done && busy))
        else begin
            $error("done and busy high in the same cycle");
            fail_count++;
        end

    one_enable: assert property (@(posedge clk) disable iff (reset)
        !(blank_enable && rect_enable))
        else begin
            $error("blank and rect commands enabled together");
            fail_count++;
        end

    write_while_busy: assert property (@(posedge clk) disable iff (reset)
        ram_write_enable |-> busy)
        else begin
            $error("frame ram written while dispatch not busy");
            fail_count++;
        end

    start_with_write: assert property (@(posedge clk) disable iff (reset)
        ram_access_start |-> ram_write_enable)
        else begin
            $error("access_start without write_enable on the ram bus");
            fail_count++;
        end

endmodule

bind command_dispatch panel_ctrl_asserts dispatch_checks (
    .clk             (clk),
    .reset           (reset),
    .busy            (busy),
    .done            (done),
    .blank_enable    (blank_enable),
    .rect_enable     (rect_enable),
    .ram_write_enable(ram_bus.write_enable),
    .ram_access_start(ram_bus.access_start)
);

/* verification/tb_panel_ctrl.sv */
//############################################################
// 32x16 panel, golden file read from the project root
//############################################################
`timescale 1ns/1ps

module tb_panel_ctrl;

    localparam int PW           = 32;
    localparam int PH           = 16;
    localparam int RESET_CYCLES = 3;
    localparam GOLDEN           = "verification/panel_golden.txt";

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    logic [51:0] cmd;
    logic [4:0]  rd_row;
    logic [5:0]  rd_column;
    logic [1:0]  rd_pixel;
    logic        busy;
    logic        done;
    logic [7:0]  rd_data;

    int seed;
    int watchdog_cycles = 0;
    int cur_test        = 0;
    int tests_run       = 0;
    int test_checks     = 0;
    int test_errors     = 0;
    int total_checks    = 0;
    int total_errors    = 0;
    int setup_errors    = 0;

    panel_ctrl_top #(
        .PANEL_WIDTH (PW),
        .PANEL_HEIGHT(PH)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .rd_row   (rd_row),
        .rd_column(rd_column),
        .rd_pixel (rd_pixel),
        .busy     (busy),
        .done     (done),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pixels a command touches once clipped to the panel
    function automatic int clipped_area(input logic [51:0] word);
        int op;
        int x;
        int y;
        int w;
        int h;
        int area;
        op   = int'(word[51:48]);
        x    = int'(word[47:42]);
        y    = int'(word[41:37]);
        w    = int'(word[36:30]);
        h    = int'(word[29:24]);
        area = 0;
        if (op == 1) begin
            area = PW * PH;
        end else if ((op == 2 || op == 3) && x < PW && y < PH) begin
            w    = (op == 3) ? 1 : ((w > PW - x) ? PW - x : w);
            h    = (op == 3) ? 1 : ((h > PH - y) ? PH - y : h);
            area = w * h;
        end
        return area;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("FAIL %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic end_test();
        if (cur_test > 0) begin
            $display("test %0d: %s, %0d checks, %0d errors", cur_test,
                     (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
            tests_run++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks   = 0;
        test_errors   = 0;
    endtask

    task automatic send_word(input logic [51:0] word);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= word;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input int budget, output bit saw_busy, output bit got_done);
        int n;
        n        = 0;
        saw_busy = 1'b0;
        got_done = 1'b0;
        while (!got_done && n < budget) begin
            @(negedge clk);
            saw_busy = saw_busy || busy;
            got_done = done;
            n++;
        end
    endtask

    task automatic run_command(input logic [51:0] word, input bit send_extra,
                               input logic [51:0] extra);
        int budget;
        bit expect_busy;
        bit saw_busy;
        bit got_done;
        budget      = clipped_area(word) * 3 + 10;
        expect_busy = (word[51:48] != 4'h0) && (word[51:48] <= 4'h3);
        send_word(word);
        if (send_extra) begin
            @(negedge clk);
            compare_value("busy", 32'(busy), 32'd1);
            send_word(extra);   // lands while busy
        end
        wait_done(budget, saw_busy, got_done);
        if (!got_done) begin
            $display("test %0d: done did not arrive within %0d cycles", cur_test, budget);
            test_errors++;
        end
        compare_value("busy", 32'(saw_busy), 32'(expect_busy));
    endtask

    task automatic read_check(input logic [4:0] row, input logic [5:0] col,
                              input logic [1:0] pix, input logic [7:0] expected);
        @(posedge clk);
        rd_row    <= row;
        rd_column <= col;
        rd_pixel  <= pix;
        @(posedge clk);
        @(negedge clk);
        compare_value($sformatf("rd_data r%0d c%0d p%0d", row, col, pix),
                      32'(rd_data), 32'(expected));
    endtask

    task automatic random_readback(input int count, input int expected);
        int row;
        int col;
        int pix;
        repeat (count) begin
            row = $unsigned($random(seed)) % PH;
            col = $unsigned($random(seed)) % PW;
            pix = $unsigned($random(seed)) % 3;
            read_check(5'(row), 6'(col), 2'(pix), 8'(expected));
        end
    endtask

    // dry pass only adds up the cycle budget
    task automatic run_golden(input bit dry, output int cycles);
        int fd;
        int c;
        int n;
        int want;
        int num;
        int row;
        int col;
        int pix;
        int data;
        logic [7:0]       kind;
        logic [51:0]      word;
        logic [51:0]      word2;
        logic [8*128-1:0] line;
        cycles = 0;
        fd     = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN);
            setup_errors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            kind = 8'(c);
            want = 0;
            case (kind)
                "#": n = $fgets(line, fd);
                "T": begin
                    n    = $fscanf(fd, "%d", num);
                    want = 1;
                    if (!dry) begin
                        end_test();
                        cur_test = num;
                    end
                end
                "C": begin
                    n       = $fscanf(fd, "%h", word);
                    want    = 1;
                    cycles += clipped_area(word) * 3 + 12;
                    if (!dry) run_command(word, 1'b0, '0);
                end
                "P": begin
                    n       = $fscanf(fd, "%h %h", word, word2);
                    want    = 2;
                    cycles += clipped_area(word) * 3 + 15;
                    if (!dry) run_command(word, 1'b1, word2);
                end
                "Z": begin
                    n       = $fscanf(fd, "%d %h", num, data);
                    want    = 2;
                    cycles += num * 3;
                    if (!dry) random_readback(num, data);
                end
                "R": begin
                    n       = $fscanf(fd, "%h %h %h %h", row, col, pix, data);
                    want    = 4;
                    cycles += 3;
                    if (!dry) read_check(5'(row), 6'(col), 2'(pix), 8'(data));
                end
                default: ;
            endcase
            if (dry && want != 0 && n != want) begin
                $display("golden file has a malformed %c line", kind);
                setup_errors++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    initial begin
        int budget_total;
        int failures;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rd_row    = '0;
        rd_column = '0;
        rd_pixel  = '0;
        seed      = 14282;
        run_golden(1'b1, budget_total);
        watchdog_cycles = (budget_total + RESET_CYCLES + 20) * 2;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        if (setup_errors == 0) begin
            run_golden(1'b0, budget_total);
        end
        end_test();
        failures = total_errors + setup_errors +
                   int'(uut.dispatch.dispatch_checks.fail_count);   // bound assertions
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, total_checks, failures);
        if (failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* flist.f */
verilog/panel_pkg.sv
verilog/fill_bus_if.sv
verilog/subcmd_fill_area.sv
verilog/cmd_blank_panel.sv
verilog/cmd_fill_rect.sv
verilog/command_dispatch.sv
verilog/frame_ram.sv
verilog/panel_ctrl_top.sv
verification/panel_ctrl_asserts.sv
verification/tb_panel_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the panel controller testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_panel_ctrl \
    -f flist.f

output=$(./obj_dir/Vtb_panel_ctrl 2>&1) || true
echo "$output"

if grep -qF -- '** PASS **' <<< "$output"; then
    exit 0
fi
exit 1

/* verification/panel_golden.txt */
# T test(dec) | C word | P word word_sent_while_busy | Z count(dec) byte | R row col pixel byte
# hex word: opcode[51:48] x1[47:42] y1[41:37] width[36:30] height[29:24] colour[23:0]
T 1
C 1000000000000
Z 24 00
T 2
C 2104143112233
R 02 04 0 11
R 02 04 1 22
R 02 04 2 33
R 04 08 2 33
R 03 06 1 22
R 02 03 0 00
R 02 09 0 00
R 01 04 0 00
R 05 08 2 00
T 3
C 37DE000AABBCC
R 0F 1F 0 AA
R 0F 1F 1 BB
R 0F 1F 2 CC
R 0F 1E 2 00
R 0E 1F 0 00
T 4
C 275C205445566
R 0E 1D 0 44
R 0E 1F 1 55
R 0F 1F 2 66
R 0E 1C 0 00
R 0D 1D 0 00
T 5
P 1000000000000 2000082FFFFFF
R 02 04 0 00
R 0F 1F 2 00
R 00 00 0 00
R 00 01 2 00
C 0000000000000
C F000000000000
